/* bench/pipeline_model.svh */
//**********************************************************************
// Reference model of the pipeline, included inside the testbench.
// Keeps its own copy of every strand's registers and one queue of
// expected retire records per strand, filled in acceptance order.
// Results follow the opcode rules, arithmetic wraps at 32 bits.
//**********************************************************************

`ifndef PIPELINE_MODEL_SVH
`define PIPELINE_MODEL_SVH

data_t model_regs [NUM_STRANDS][NUM_REGS];		// Architectural state per strand
retire_t expected_q [NUM_STRANDS][$];			// Records still to retire

// Back to the reset state, all registers zero
function automatic void clear_model();
	for (int s = 0; s < NUM_STRANDS; s++)
	begin
		for (int r = 0; r < NUM_REGS; r++)
			model_regs[s][r] = '0;
		expected_q[s].delete();
	end
endfunction

function automatic data_t predict_result(instr_t i);
	data_t a;
	data_t b;

	a = model_regs[i.strand][i.src1];
	b = model_regs[i.strand][i.src2];
	case (i.op)
		op_add: return a + b;
		op_sub: return a - b;
		op_and: return a & b;
		op_or: return a | b;
		op_xor: return a ^ b;
		op_shl: return a << b[4:0];					// Low 5 bits only
		op_addi: return a + {{16{i.imm[15]}}, i.imm};	// Sign-extended
		default: return {16'h0000, i.imm};			// op_li, zero-extended
	endcase
endfunction

// Accepted instruction updates the model in program order
function automatic void record_accepted(instr_t i);
	retire_t r;

	r.strand = i.strand;
	r.dest = i.dest;
	r.value = predict_result(i);
	model_regs[i.strand][i.dest] = r.value;
	expected_q[i.strand].push_back(r);
endfunction

function automatic int pending_count();
	int n;

	n = 0;
	for (int s = 0; s < NUM_STRANDS; s++)
		n += expected_q[s].size();
	return n;
endfunction

`endif

/* bench/tb_pipeline.sv */
//**********************************************************************
// Testbench for the four-strand pipeline, random stimulus from a
// fixed seed checked against the included reference model.
// Handshakes are sampled on the falling edge, inputs change on the
// rising edge. Every wait is bounded by its own cycle limit.
//**********************************************************************

`timescale 1ns/100ps

module tb_pipeline
	import core_pkg::*, isa_pkg::*;
	();

	localparam int WAIT_LIMIT = 200;		// Cycles for one input transfer
	localparam int DRAIN_LIMIT = 2000;		// Cycles to empty the pipeline
	localparam int FILL_LIMIT = 200;		// Cycles for in_ready to fall

	logic clk;
	logic reset;
	logic in_valid;
	logic in_ready;
	instr_t in_instr;
	logic retire_valid;
	logic retire_ready;
	retire_t retire;

	int seed;					// Instruction stream
	int ready_seed;				// retire_ready pattern
	int ready_mode;				// 0 high, 1 random, 2 low
	int error_count;
	int check_count;
	int accepted_count;
	int retired_count;
	int tests_failed;
	int errors_before;

	`include "pipeline_model.svh"

	pipeline_top #(.STRAND_QUEUE_DEPTH(4), .RETIRE_QUEUE_DEPTH(4)) UUT(.clk, .reset,
		.in_valid, .in_ready, .in_instr, .retire_valid, .retire_ready, .retire);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = !clk;		// 100 ns period
	end

	// Output side back-pressure
	initial
	begin
		forever
		begin
			@(posedge clk);
			case (ready_mode)
				0: retire_ready <= 1'b1;
				1: retire_ready <= ($random(ready_seed) & 3) != 0;	// About 75 percent
				default: retire_ready <= 1'b0;
			endcase
		end
	end

	// Monitor, both handshakes are stable here
	initial
	begin
		retire_t exp;

		forever
		begin
			@(negedge clk);
			if (!reset && in_valid && in_ready)
			begin
				record_accepted(in_instr);
				accepted_count++;
			end
			if (!reset && retire_valid && retire_ready)
			begin
				retired_count++;
				check_count++;
				if (expected_q[retire.strand].size() == 0)
				begin
					$display("Unexpected retire record on strand %0d", retire.strand);
					error_count++;
				end
				else
				begin
					exp = expected_q[retire.strand].pop_front();
					if (retire.dest != exp.dest)
					begin
						$display("Fail retire.dest got %h expected %h", retire.dest, exp.dest);
						error_count++;
					end
					if (retire.value != exp.value)
					begin
						$display("Fail retire.value got %h expected %h (strand %0d)",
							retire.value, exp.value, retire.strand);
						error_count++;
					end
				end
			end
		end
	end

	function automatic instr_t make_instr(int s, alu_op_t op, int d, int a, int b, int imm);
		instr_t i;

		i.strand = strand_id_t'(s);
		i.op = op;
		i.dest = reg_index_t'(d);
		i.src1 = reg_index_t'(a);
		i.src2 = reg_index_t'(b);
		i.imm = 16'(imm);
		return i;
	endfunction

	function automatic instr_t random_instr();
		return make_instr($random(seed), alu_op_t'(3'($random(seed))), $random(seed),
			$random(seed), $random(seed), $random(seed));
	endfunction

	// Caller holds in_valid, returns right after the transfer edge
	task automatic finish_transfer();
		int cycles;

		cycles = 0;
		@(negedge clk);
		while (!in_ready && cycles < WAIT_LIMIT)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!in_ready)
		begin
			$display("Timeout waiting for in_ready, instruction never accepted");
			error_count++;
		end
		@(posedge clk);
		in_valid <= 1'b0;
	endtask

	task automatic send_instr(instr_t i);
		in_valid <= 1'b1;
		in_instr <= i;
		finish_transfer();
	endtask

	task automatic drain_pipeline();
		int cycles;

		cycles = 0;
		while (pending_count() != 0 && cycles < DRAIN_LIMIT)
		begin
			@(negedge clk);
			cycles++;
		end
		@(negedge clk);		// Monitor settles this edge
		if (pending_count() != 0)
		begin
			$display("Timeout draining, %0d records never retired", pending_count());
			error_count++;
		end
	endtask

	task automatic check_counts();
		check_count++;
		if (retired_count != accepted_count)
		begin
			$display("Fail retired count got %h expected %h", retired_count, accepted_count);
			error_count++;
		end
	endtask

	task automatic report_test(int n, string name);
		if (error_count == errors_before)
			$display("Test %0d %s: ok", n, name);
		else
		begin
			$display("Test %0d %s: failed, %0d errors", n, name, error_count - errors_before);
			tests_failed++;
		end
		errors_before = error_count;
	endtask

	initial
	begin
		int cycles;
		logic stalled;

		seed = 57178;
		ready_seed = seed + 1;		// Separate stream from the instructions
		ready_mode = 0;
		reset = 1'b1;
		in_valid = 1'b0;
		in_instr = '0;
		retire_ready = 1'b0;
		error_count = 0;
		check_count = 0;
		accepted_count = 0;
		retired_count = 0;
		tests_failed = 0;
		errors_before = 0;
		clear_model();
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		// Test 1, idle state and unwritten registers
		@(negedge clk);
		check_count += 2;
		if (retire_valid !== 1'b0)
		begin
			$display("Fail retire_valid got %h expected %h", retire_valid, 1'b0);
			error_count++;
		end
		if (in_ready !== 1'b1)
		begin
			$display("Fail in_ready got %h expected %h", in_ready, 1'b1);
			error_count++;
		end
		@(posedge clk);
		for (int s = 0; s < NUM_STRANDS; s++)
			send_instr(make_instr(s, op_add, s + 1, $random(seed), $random(seed), 0));
		drain_pipeline();
		report_test(1, "reset state");

		// Test 2, dependent chain on one strand, back to back
		@(posedge clk);
		for (int k = 0; k < 5; k++)
		begin
			send_instr(make_instr(2, op_li, 1, 0, 0, $random(seed)));
			send_instr(make_instr(2, op_addi, 2, 1, 0, $random(seed)));
			send_instr(make_instr(2, op_sub, 3, 2, 1, 0));
			send_instr(make_instr(2, op_shl, 4, 3, 2, 0));
			send_instr(make_instr(2, op_addi, 1, 4, 0, $random(seed)));
		end
		drain_pipeline();
		report_test(2, "dependent chain");

		// Test 3, all strands and opcodes
		@(posedge clk);
		repeat (200) send_instr(random_instr());
		drain_pipeline();
		report_test(3, "random strands");

		// Test 4, random retire back-pressure
		ready_mode = 1;
		@(posedge clk);
		repeat (200) send_instr(random_instr());
		@(negedge clk);
		ready_mode = 0;
		drain_pipeline();
		check_counts();
		report_test(4, "random back-pressure");

		// Test 5, retire held low until input stalls
		ready_mode = 2;
		@(posedge clk);
		stalled = 1'b0;
		cycles = 0;
		in_valid <= 1'b1;
		in_instr <= random_instr();
		while (!stalled && cycles < FILL_LIMIT)
		begin
			@(negedge clk);
			if (!in_ready)
				stalled = 1'b1;		// Held instruction stays offered
			else
			begin
				@(posedge clk);
				in_instr <= random_instr();
				cycles++;
			end
		end
		if (!stalled)
		begin
			$display("Timeout, in_ready never fell with retire_ready low");
			error_count++;
			@(negedge clk);
		end
		ready_mode = 0;
		finish_transfer();
		drain_pipeline();
		check_counts();
		report_test(5, "full queues");

		$display("Tests 5, failed %0d, checks %0d, errors %0d, accepted %0d, retired %0d",
			tests_failed, check_count, error_count, accepted_count, retired_count);
		if (error_count == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

/* hdl/core_pkg.sv */
//**********************************************************************
// Machine configuration shared by every pipeline block.
// Strand count must stay a power of two for the strand id wrap.
// Register file is NUM_STRANDS x NUM_REGS words, all cleared on reset.
//**********************************************************************

package core_pkg;

	// Hardware strands sharing one integer pipeline
	localparam int NUM_STRANDS = 4;

	// Scalar registers per strand
	localparam int NUM_REGS = 8;

	// Register and ALU width
	localparam int DATA_WIDTH = 32;

	localparam int STRAND_BITS = $clog2(NUM_STRANDS);	// Strand id width
	localparam int REG_BITS = $clog2(NUM_REGS);		// Register index width

	// Strand number carried with every instruction
	typedef logic [STRAND_BITS-1:0] strand_id_t;

	// Register number inside one strand
	typedef logic [REG_BITS-1:0] reg_index_t;

	// Register value
	typedef logic [DATA_WIDTH-1:0] data_t;

endpackage

/* hdl/execute_stage.sv */
//**********************************************************************
// Operand fetch, bypass, ALU and writeback register.
// Sources come from the writeback register when it holds the same
// strand and destination, else from the register file.
// The register file write and the retire push share one handshake,
// so a result held by back-pressure is written exactly once.
//**********************************************************************

`timescale 1ns/100ps

module execute_stage
	import core_pkg::*, isa_pkg::*;

	(input					clk,
	input					reset,
	input					issue_valid,
	output logic			issue_ready,
	input instr_t			issue,
	output strand_id_t		rd_strand,
	output reg_index_t		rd_index1,
	output reg_index_t		rd_index2,
	input data_t			rd_value1,
	input data_t			rd_value2,
	output logic			wr_enable,
	output strand_id_t		wr_strand,
	output reg_index_t		wr_index,
	output data_t			wr_value,
	output logic			retire_valid,
	input					retire_ready,
	output retire_t			retire);

	localparam int SHAMT_BITS = $clog2(DATA_WIDTH);	// Shift amount bits

	logic wb_valid;			// Writeback register occupied
	retire_t wb;			// Writeback register
	logic wb_done;			// Result leaves this cycle
	logic bypass1;
	logic bypass2;
	data_t operand1;
	data_t operand2;
	data_t imm_sext;
	data_t imm_zext;
	data_t result;

	assign wb_done = wb_valid && retire_ready;
	assign issue_ready = !wb_valid || retire_ready;	// Slot free or draining

	// Register file read side, addressed by the issue slot
	assign rd_strand = issue.strand;
	assign rd_index1 = issue.src1;
	assign rd_index2 = issue.src2;

	// Result ahead of us is not yet in the register file
	assign bypass1 = wb_valid && wb.strand == issue.strand && wb.dest == issue.src1;
	assign bypass2 = wb_valid && wb.strand == issue.strand && wb.dest == issue.src2;
	assign operand1 = bypass1 ? wb.value : rd_value1;
	assign operand2 = bypass2 ? wb.value : rd_value2;

	assign imm_sext = {{(DATA_WIDTH - IMM_WIDTH){issue.imm[IMM_WIDTH-1]}}, issue.imm};
	assign imm_zext = {{(DATA_WIDTH - IMM_WIDTH){1'b0}}, issue.imm};

	always_comb
	begin
		case (issue.op)
			op_add: result = operand1 + operand2;
			op_sub: result = operand1 - operand2;
			op_and: result = operand1 & operand2;
			op_or: result = operand1 | operand2;
			op_xor: result = operand1 ^ operand2;
			op_shl: result = operand1 << operand2[SHAMT_BITS-1:0];
			op_addi: result = operand1 + imm_sext;
			op_li: result = imm_zext;
			default: result = '0;
		endcase
	end

	// Write port and retire push move together
	assign wr_enable = wb_done;
	assign wr_strand = wb.strand;
	assign wr_index = wb.dest;
	assign wr_value = wb.value;
	assign retire_valid = wb_valid;
	assign retire = wb;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			wb_valid <= 1'b0;
		else if (issue_ready)
			wb_valid <= issue_valid;
	end

	always_ff @(posedge clk)
	begin
		if (issue_valid && issue_ready)
		begin
			wb.strand <= issue.strand;
			wb.dest <= issue.dest;
			wb.value <= result;
		end
	end

	// Held retire record stays put until the retire queue takes it
	assert property (@(posedge clk) disable iff (reset)
		retire_valid && !retire_ready |=> retire_valid && $stable(retire))
		else $error("execute_stage: retire changed while stalled");

endmodule

/* hdl/instruction_steer.sv */
//**********************************************************************
// One-entry input buffer that routes each instruction to its strand
// queue. An accepted instruction is offered one cycle later.
// A full queue for the held strand stalls all input, even for others.
//**********************************************************************

`timescale 1ns/100ps

module instruction_steer
	import core_pkg::*, isa_pkg::*;

	(input								clk,
	input								reset,
	input								in_valid,
	output logic						in_ready,
	input instr_t						in_instr,
	output logic [NUM_STRANDS-1:0]		push_valid,
	input [NUM_STRANDS-1:0]				push_ready,
	output instr_t						push_instr);

	logic held_valid;		// Buffer occupied
	instr_t held_instr;		// Buffered instruction
	logic drain;			// Held entry taken this cycle

	assign drain = held_valid && push_ready[held_instr.strand];
	assign in_ready = !held_valid || drain;		// Empty or emptying
	assign push_instr = held_instr;				// Shared by all queues

	always_comb
	begin
		push_valid = '0;
		if (held_valid)
			push_valid[held_instr.strand] = 1'b1;	// Only the owning strand
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			held_valid <= 1'b0;
		else if (in_ready)
			held_valid <= in_valid;		// Refill or go empty
	end

	always_ff @(posedge clk)
	begin
		if (in_valid && in_ready)
			held_instr <= in_instr;
	end

	// At most one strand queue sees a push
	assert property (@(posedge clk) disable iff (reset) $onehot0(push_valid))
		else $error("instruction_steer: push_valid not one-hot %b", push_valid);

endmodule

/* hdl/isa_pkg.sv */
//**********************************************************************
// Operation codes and the records that flow through the pipeline.
// Instructions arrive already decoded, no encoding is defined here.
// All arithmetic wraps modulo 2**DATA_WIDTH.
//**********************************************************************

package isa_pkg;

	import core_pkg::*;

	localparam int IMM_WIDTH = 16;	// Immediate field width

	typedef enum logic [2:0]
	{
		op_add,		// src1 + src2
		op_sub,		// src1 - src2
		op_and,		// Bitwise and
		op_or,		// Bitwise or
		op_xor,		// Bitwise xor
		op_shl,		// src1 << low 5 bits of src2
		op_addi,	// src1 + sign-extended imm
		op_li		// Zero-extended imm
	} alu_op_t;

	// Decoded instruction, tagged with its strand
	typedef struct packed
	{
		strand_id_t strand;
		alu_op_t op;
		reg_index_t dest;
		reg_index_t src1;
		reg_index_t src2;
		logic [IMM_WIDTH-1:0] imm;
	} instr_t;

	// Retire record, one per completed instruction
	typedef struct packed
	{
		strand_id_t strand;
		reg_index_t dest;
		data_t value;
	} retire_t;

endpackage

/* hdl/pipeline_top.sv */
//**********************************************************************
// Four-strand integer pipeline: steering buffer, strand queues,
// round-robin select, execute with register file, retire queue.
// Per-strand retire order matches acceptance order, no order across
// strands. Acceptance to retire_valid is at least 4 cycles.
//**********************************************************************

`timescale 1ns/100ps

module pipeline_top
	import core_pkg::*, isa_pkg::*;

	#(parameter int STRAND_QUEUE_DEPTH = 4,
	parameter int RETIRE_QUEUE_DEPTH = 4)

	(input				clk,
	input				reset,
	input				in_valid,
	output logic		in_ready,
	input instr_t		in_instr,
	output logic		retire_valid,
	input				retire_ready,
	output retire_t		retire);

	logic [NUM_STRANDS-1:0] push_valid;		// Steering to queues
	logic [NUM_STRANDS-1:0] push_ready;
	instr_t push_instr;
	logic [NUM_STRANDS-1:0] head_valid;		// Queue heads
	instr_t head_instr [NUM_STRANDS];
	logic [NUM_STRANDS-1:0] pop;
	logic issue_valid;						// Issue slot
	logic issue_ready;
	instr_t issue;
	strand_id_t rd_strand;					// Register file reads
	reg_index_t rd_index1;
	reg_index_t rd_index2;
	data_t rd_value1;
	data_t rd_value2;
	logic wr_enable;						// Register file write
	strand_id_t wr_strand;
	reg_index_t wr_index;
	data_t wr_value;
	logic ex_retire_valid;					// Execute to retire queue
	logic ex_retire_ready;
	retire_t ex_retire;

	instruction_steer instruction_steer(.clk, .reset, .in_valid, .in_ready, .in_instr,
		.push_valid, .push_ready, .push_instr);

	for (genvar s = 0; s < NUM_STRANDS; s++)
	begin : g_strand_queue
		sync_fifo #(.DEPTH(STRAND_QUEUE_DEPTH), .item_t(instr_t)) queue(.clk, .reset,
			.in_valid(push_valid[s]), .in_ready(push_ready[s]), .in_item(push_instr),
			.out_valid(head_valid[s]), .out_ready(pop[s]), .out_item(head_instr[s]));
	end

	strand_select strand_select(.clk, .reset, .head_valid, .head_instr, .pop,
		.issue_valid, .issue_ready, .issue);

	scalar_register_file scalar_register_file(.clk, .reset, .rd_strand, .rd_index1,
		.rd_index2, .rd_value1, .rd_value2, .wr_enable, .wr_strand, .wr_index, .wr_value);

	execute_stage execute_stage(.clk, .reset, .issue_valid, .issue_ready, .issue,
		.rd_strand, .rd_index1, .rd_index2, .rd_value1, .rd_value2,
		.wr_enable, .wr_strand, .wr_index, .wr_value,
		.retire_valid(ex_retire_valid), .retire_ready(ex_retire_ready), .retire(ex_retire));

	sync_fifo #(.DEPTH(RETIRE_QUEUE_DEPTH), .item_t(retire_t)) retire_queue(.clk, .reset,
		.in_valid(ex_retire_valid), .in_ready(ex_retire_ready), .in_item(ex_retire),
		.out_valid(retire_valid), .out_ready(retire_ready), .out_item(retire));

endmodule

/* hdl/scalar_register_file.sv */
//**********************************************************************
// Per-strand scalar registers, two combinational reads, one write.
// A write lands on the clock edge and is visible to reads right after.
// Every register of every strand is cleared by reset.
//**********************************************************************

`timescale 1ns/100ps

module scalar_register_file
	import core_pkg::*;

	(input					clk,
	input					reset,
	input strand_id_t		rd_strand,
	input reg_index_t		rd_index1,
	input reg_index_t		rd_index2,
	output data_t			rd_value1,
	output data_t			rd_value2,
	input					wr_enable,
	input strand_id_t		wr_strand,
	input reg_index_t		wr_index,
	input data_t			wr_value);

	data_t regs [NUM_STRANDS][NUM_REGS];	// One bank per strand

	assign rd_value1 = regs[rd_strand][rd_index1];
	assign rd_value2 = regs[rd_strand][rd_index2];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int s = 0; s < NUM_STRANDS; s++)
			begin
				for (int r = 0; r < NUM_REGS; r++)
					regs[s][r] <= '0;
			end
		end
		else if (wr_enable)
			regs[wr_strand][wr_index] <= wr_value;
	end

endmodule

/* hdl/strand_select.sv */
//**********************************************************************
// Round-robin strand selector with a registered issue slot.
// Search starts after the last granted strand, strand 0 first after
// reset. A queue is popped only when the issue slot is free or being
// taken, so a stalled slot never loses or duplicates an instruction.
//**********************************************************************

`timescale 1ns/100ps

module strand_select
	import core_pkg::*, isa_pkg::*;

	(input								clk,
	input								reset,
	input [NUM_STRANDS-1:0]				head_valid,
	input instr_t						head_instr [NUM_STRANDS],
	output logic [NUM_STRANDS-1:0]		pop,
	output logic						issue_valid,
	input								issue_ready,
	output instr_t						issue);

	strand_id_t last_grant;		// Strand issued most recently
	strand_id_t grant;			// Strand picked this cycle
	logic grant_found;			// Some queue is non-empty
	logic slot_free;			// Issue slot can load

	assign slot_free = !issue_valid || issue_ready;

	// Rotating priority search
	always_comb
	begin
		strand_id_t cand;

		grant = last_grant;
		grant_found = 1'b0;
		for (int i = 1; i <= NUM_STRANDS; i++)
		begin
			cand = strand_id_t'((int'(last_grant) + i) % NUM_STRANDS);
			if (!grant_found && head_valid[cand])
			begin
				grant = cand;
				grant_found = 1'b1;
			end
		end
	end

	always_comb
	begin
		pop = '0;
		if (slot_free && grant_found)
			pop[grant] = 1'b1;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			issue_valid <= 1'b0;
			last_grant <= strand_id_t'(NUM_STRANDS - 1);	// So strand 0 goes first
		end
		else if (slot_free)
		begin
			issue_valid <= grant_found;
			if (grant_found)
				last_grant <= grant;
		end
	end

	always_ff @(posedge clk)
	begin
		if (slot_free && grant_found)
			issue <= head_instr[grant];		// Head of popped queue
	end

	// Only one queue popped per cycle
	assert property (@(posedge clk) disable iff (reset) $onehot0(pop))
		else $error("strand_select: pop not one-hot %b", pop);

endmodule

/* hdl/sync_fifo.sv */
//**********************************************************************
// Synchronous queue with valid/ready on both sides.
// Push and pop may happen in the same cycle.
// A pushed entry reaches the head one cycle later, no fall-through.
// When full, in_ready stays low even if the head is popped that cycle.
//**********************************************************************

`timescale 1ns/100ps

module sync_fifo
	#(parameter int DEPTH = 4,
	parameter type item_t = logic [7:0])

	(input				clk,
	input				reset,
	input				in_valid,
	output logic		in_ready,
	input item_t		in_item,
	output logic		out_valid,
	input				out_ready,
	output item_t		out_item);

	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	item_t storage [DEPTH];				// Circular buffer
	logic [PTR_BITS-1:0] rd_ptr;		// Head slot
	logic [PTR_BITS-1:0] wr_ptr;		// Next free slot
	logic [CNT_BITS-1:0] count;			// Occupancy
	logic push;
	logic pop;

	assign in_ready = count != CNT_BITS'(DEPTH);	// Not full
	assign out_valid = count != '0;					// Not empty
	assign out_item = storage[rd_ptr];
	assign push = in_valid && in_ready;
	assign pop = out_valid && out_ready;

	always_ff @(posedge clk)
	begin
		if (push)
			storage[wr_ptr] <= in_item;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;	// Wrap

			if (pop)
				rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;	// Both or neither
			endcase
		end
	end

	// Occupancy bound, would mean a lost or duplicated entry
	assert property (@(posedge clk) disable iff (reset) count <= DEPTH)
		else $error("sync_fifo: count %0d exceeds depth %0d", count, DEPTH);

endmodule

/* tb.f */
+incdir+bench
hdl/core_pkg.sv
hdl/isa_pkg.sv
hdl/sync_fifo.sv
hdl/instruction_steer.sv
hdl/strand_select.sv
hdl/scalar_register_file.sv
hdl/execute_stage.sv
hdl/pipeline_top.sv
bench/tb_pipeline.sv
